// File: hdl/ps2_mouse_pkg.sv
package ps2_mouse_pkg;

	// Command bytes sent by the host to the mouse
	localparam logic [7:0] PS2_CMD_RESET  = 8'hFF;
	localparam logic [7:0] PS2_CMD_ENABLE = 8'hF4;

	// Reply bytes sent by the mouse to the host
	localparam logic [7:0] PS2_REP_BAT_OK = 8'hAA;
	localparam logic [7:0] PS2_REP_ACK    = 8'hFA;
	localparam logic [7:0] PS2_REP_ID     = 8'h00;

	// The host holds the PS/2 clock low this long before a request to send (100 us)
	localparam int INHIBIT_CYCLES = 5000;

	// Longest gap between PS/2 clock edges inside a frame before the frame is dropped
	localparam int TIMEOUT_CYCLES = 20000;

	// Width of the axis flush divider, one flush tick every 2**FLUSH_BITS cycles
	localparam int FLUSH_BITS = 12;

	// Movement accumulator width in two's complement
	localparam int ACC_BITS = 10;

	// Bring-up and packet tracking states of the controller
	typedef enum logic [2:0] {
		ST_INIT,
		ST_ID,
		ST_SETUP,
		ST_BYTE0,
		ST_BYTE1,
		ST_BYTE2
	} mouse_state_e;

	// Received byte, strobe is high for one cycle per good frame
	typedef struct packed {
		logic       strobe;
		logic [7:0] data;
	} ps2_rx_t;

	// Transmit request, req is a single-cycle pulse
	typedef struct packed {
		logic       req;
		logic [7:0] data;
	} ps2_tx_t;

	// One movement value for an axis
	// The magnitude is the raw packet byte and the sign comes from byte 0
	typedef struct packed {
		logic       strobe;
		logic       sign;
		logic [7:0] magnitude;
	} axis_move_t;

endpackage

// File: hdl/ps2_link.sv
`timescale 1ns/1ps

module ps2_link
	import ps2_mouse_pkg::*;
(
	input  logic    sysclk,
	input  logic    reset,
	input  logic    ps2clk_in,
	input  logic    ps2dat_in,
	output logic    ps2clk_oe,
	output logic    ps2dat_oe,
	output ps2_rx_t rx,
	input  ps2_tx_t tx,
	output logic    timeout
);
	// Link states, a frame is open in L_RX and L_TX
	typedef enum logic [2:0] {
		L_IDLE,
		L_RX,
		L_INHIBIT,
		L_START,
		L_TX
	} link_state_e;

	// Bits 0 and 1 form the synchronizer, bit 2 is the previous synchronized value
	logic [2:0]                          clk_sync;
	logic [1:0]                          dat_sync;
	logic                                fall;
	logic                                dat_in;
	link_state_e                         state;
	logic [3:0]                          bit_cnt;
	logic [$clog2(TIMEOUT_CYCLES+1)-1:0] timer;
	logic [8:0]                          rx_shift;
	logic [9:0]                          tx_shift;
	logic                                rx_strobe;
	logic                                frame_open;
	logic                                stalled;
	logic                                inhibit_done;

	// Both lines idle high, so the synchronizers come out of reset at 1
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			clk_sync <= 3'b111;
			dat_sync <= 2'b11;
		end else begin
			clk_sync <= {clk_sync[1:0], ps2clk_in};
			dat_sync <= {dat_sync[0], ps2dat_in};
		end
	end

	// The device changes data while the clock is high, so data is stable at a falling edge
	assign fall   = clk_sync[2] & ~clk_sync[1];
	assign dat_in = dat_sync[1];

	// One timer serves the clock inhibit and the stalled frame watchdog
	assign frame_open   = (state == L_RX) || (state == L_TX);
	assign stalled      = frame_open && (timer == TIMEOUT_CYCLES - 1);
	assign inhibit_done = (state == L_INHIBIT) && (timer == INHIBIT_CYCLES - 1);

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			state     <= L_IDLE;
			bit_cnt   <= '0;
			timer     <= '0;
			ps2clk_oe <= 1'b0;
			ps2dat_oe <= 1'b0;
			rx_strobe <= 1'b0;
			timeout   <= 1'b0;
		end else begin
			rx_strobe <= 1'b0;
			timeout   <= 1'b0;
			if (stalled) begin
				// Drop the frame and release both lines
				state     <= L_IDLE;
				timer     <= '0;
				ps2clk_oe <= 1'b0;
				ps2dat_oe <= 1'b0;
				timeout   <= 1'b1;
			end else begin
				case (state)
					L_IDLE: begin
						timer   <= '0;
						bit_cnt <= '0;
						// A host request wins over a start bit seen in the same cycle
						if (tx.req) begin
							state     <= L_INHIBIT;
							ps2clk_oe <= 1'b1;
						end else if (fall && !dat_in) begin
							state   <= L_RX;
							bit_cnt <= 4'd1;
						end
					end
					L_RX: begin
						if (fall) begin
							timer   <= '0;
							bit_cnt <= bit_cnt + 4'd1;
							// Edge 11 is the stop bit, which must be high with odd parity
							if (bit_cnt == 4'd10) begin
								state     <= L_IDLE;
								rx_strobe <= dat_in && (^rx_shift);
							end
						end else begin
							timer <= timer + 1'b1;
						end
					end
					L_INHIBIT: begin
						timer <= timer + 1'b1;
						// Pull data low for the start bit while the clock is still held
						if (inhibit_done) begin
							state     <= L_START;
							timer     <= '0;
							ps2dat_oe <= 1'b1;
						end
					end
					L_START: begin
						// Releasing the clock hands clocking over to the device
						state     <= L_TX;
						bit_cnt   <= '0;
						ps2clk_oe <= 1'b0;
					end
					L_TX: begin
						if (fall) begin
							timer   <= '0;
							bit_cnt <= bit_cnt + 4'd1;
							if (bit_cnt == 4'd10) begin
								// The device acknowledges by holding data low
								// A missing acknowledge is flagged like a stalled frame
								state   <= L_IDLE;
								timeout <= dat_in;
							end else begin
								ps2dat_oe <= ~tx_shift[0];
							end
						end else begin
							timer <= timer + 1'b1;
						end
					end
					default: state <= L_IDLE;
				endcase
			end
		end
	end

	// Shift registers for the frame payload
	// Receive shifts in data and parity LSB first, transmit holds data, parity and stop
	always_ff @(posedge sysclk) begin
		if (state == L_RX && fall && bit_cnt != 4'd10) begin
			rx_shift <= {dat_in, rx_shift[8:1]};
		end
		if (state == L_IDLE && tx.req) begin
			tx_shift <= {1'b1, ~^tx.data, tx.data};
		end else if (state == L_TX && fall && bit_cnt != 4'd10) begin
			tx_shift <= {1'b1, tx_shift[9:1]};
		end
	end

	assign rx = '{strobe: rx_strobe, data: rx_shift[7:0]};

	// The controller only requests right after a receive or a timeout, when the link is idle
	assert property (@(posedge sysclk) disable iff (reset) tx.req |-> (state == L_IDLE));

endmodule

// File: hdl/mouse_ctrl.sv
`timescale 1ns/1ps

module mouse_ctrl
	import ps2_mouse_pkg::*;
(
	input  logic       sysclk,
	input  logic       reset,
	input  ps2_rx_t    rx,
	input  logic       timeout,
	output ps2_tx_t    tx,
	output axis_move_t x_move,
	output axis_move_t y_move,
	output logic       button
);
	mouse_state_e state;
	mouse_state_e state_next;
	logic         nreq;
	logic [7:0]   nbyte;
	logic         byte_ok;
	logic         pkt_start;
	logic         x_sign;
	logic         y_sign;

	// A received byte only counts when no timeout arrives with it
	assign byte_ok = rx.strobe && !timeout;

	// Byte 0 must have bit 3 set, otherwise the controller waits for packet alignment
	assign pkt_start = byte_ok && (state == ST_BYTE0) && rx.data[3];

	// Next state and command decision, the command byte defaults to Reset
	always_comb begin
		state_next = state;
		nreq       = 1'b0;
		nbyte      = PS2_CMD_RESET;
		if (timeout) begin
			state_next = ST_INIT;
			nreq       = 1'b1;
		end else if (rx.strobe) begin
			case (state)
				ST_INIT: begin
					// An acknowledge of our own Reset is expected before the self-test reply
					if (rx.data == PS2_REP_BAT_OK) begin
						state_next = ST_ID;
					end else if (rx.data != PS2_REP_ACK) begin
						nreq = 1'b1;
					end
				end
				ST_ID: begin
					nreq = 1'b1;
					if (rx.data == PS2_REP_ID) begin
						nbyte      = PS2_CMD_ENABLE;
						state_next = ST_SETUP;
					end else begin
						state_next = ST_INIT;
					end
				end
				ST_SETUP: begin
					if (rx.data == PS2_REP_ACK) begin
						state_next = ST_BYTE0;
					end else begin
						nreq       = 1'b1;
						state_next = ST_INIT;
					end
				end
				ST_BYTE0: begin
					if (rx.data[3]) begin
						state_next = ST_BYTE1;
					end
				end
				ST_BYTE1: state_next = ST_BYTE2;
				ST_BYTE2: state_next = ST_BYTE0;
				default:  state_next = ST_INIT;
			endcase
		end
	end

	// The request is registered, so it reaches the link one cycle after the strobe
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			state <= ST_INIT;
			tx    <= '0;
		end else begin
			state <= state_next;
			tx    <= '{req: nreq, data: nbyte};
		end
	end

	// Signs of both axes come from byte 0 bits 4 and 5
	always_ff @(posedge sysclk) begin
		if (pkt_start) begin
			x_sign <= rx.data[4];
			y_sign <= rx.data[5];
		end
	end

	// Movement pulses follow byte 1 for X and byte 2 for Y
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			x_move <= '0;
			y_move <= '0;
			button <= 1'b1;
		end else begin
			x_move <= '{strobe: byte_ok && (state == ST_BYTE1), sign: x_sign, magnitude: rx.data};
			y_move <= '{strobe: byte_ok && (state == ST_BYTE2), sign: y_sign, magnitude: rx.data};
			// The Mac button line is active low
			if (pkt_start) begin
				button <= ~rx.data[0];
			end
		end
	end

	// A command always waits for a fresh receive or timeout, never back to back
	assert property (@(posedge sysclk) disable iff (reset) tx.req |=> !tx.req);

endmodule

// File: hdl/quad_axis.sv
`timescale 1ns/1ps

module quad_axis
	import ps2_mouse_pkg::*;
(
	input  logic       sysclk,
	input  logic       reset,
	input  axis_move_t move,
	output logic       q1,
	output logic       q2
);
	logic [FLUSH_BITS-1:0] flush_div;
	logic                  tick;
	logic [ACC_BITS-1:0]   acc;
	logic [ACC_BITS-1:0]   acc_mag;
	logic [ACC_BITS-1:0]   move_ext;
	logic                  do_add;
	logic                  do_step;

	// The free-running divider gives one flush tick each time it wraps to zero
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			flush_div <= '0;
		end else begin
			flush_div <= flush_div + 1'b1;
		end
	end
	assign tick = (flush_div == '0);

	// Sign and magnitude together form a 9-bit two's complement value
	assign move_ext = {{(ACC_BITS - 8){move.sign}}, move.magnitude};

	// Top two bits equal means the sum still fits in the accumulator
	assign do_add = move.strobe && (acc[ACC_BITS-1] == acc[ACC_BITS-2]);

	// A tick is lost when an add lands in the same cycle
	assign do_step = tick && (acc != '0) && !do_add;

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			acc <= '0;
		end else if (do_add) begin
			acc <= acc + move_ext;
		end else if (do_step) begin
			// Step one count toward zero
			if (acc[ACC_BITS-1]) begin
				acc <= acc + 1'b1;
			end else begin
				acc <= acc - 1'b1;
			end
		end
	end

	// Each step toggles q1, and q2 carries the direction relative to the new q1
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			q1 <= 1'b0;
			q2 <= 1'b0;
		end else if (do_step) begin
			q1 <= ~q1;
			// For negative motion q2 follows the new q1
			q2 <= acc[ACC_BITS-1] ? ~q1 : q1;
		end
	end

	// Distance of the accumulator from zero as an unsigned count
	assign acc_mag = acc[ACC_BITS-1] ? -acc : acc;

	// A flush tick without a move takes exactly one count off a nonzero accumulator
	assert property (@(posedge sysclk) disable iff (reset)
		(tick && !move.strobe && acc != '0) |=> (acc_mag == $past(acc_mag) - 1'b1));

endmodule

// File: hdl/ps2_mouse.sv
`timescale 1ns/1ps

module ps2_mouse
	import ps2_mouse_pkg::*;
(
	input  logic sysclk,
	input  logic reset,
	input  logic ps2clk_in,
	input  logic ps2dat_in,
	output logic ps2clk_oe,
	output logic ps2dat_oe,
	output logic x1,
	output logic x2,
	output logic y1,
	output logic y2,
	output logic button
);
	ps2_rx_t    rx;
	ps2_tx_t    tx;
	logic       timeout;
	axis_move_t x_move;
	axis_move_t y_move;

	// PS/2 host side of the open-drain lines
	ps2_link u_link (
		.sysclk    (sysclk),
		.reset     (reset),
		.ps2clk_in (ps2clk_in),
		.ps2dat_in (ps2dat_in),
		.ps2clk_oe (ps2clk_oe),
		.ps2dat_oe (ps2dat_oe),
		.rx        (rx),
		.tx        (tx),
		.timeout   (timeout)
	);

	// Bring-up and packet decoding
	mouse_ctrl u_ctrl (
		.sysclk  (sysclk),
		.reset   (reset),
		.rx      (rx),
		.timeout (timeout),
		.tx      (tx),
		.x_move  (x_move),
		.y_move  (y_move),
		.button  (button)
	);

	// X and Y quadrature outputs come from the same axis module
	quad_axis u_xaxis (
		.sysclk (sysclk),
		.reset  (reset),
		.move   (x_move),
		.q1     (x1),
		.q2     (x2)
	);

	quad_axis u_yaxis (
		.sysclk (sysclk),
		.reset  (reset),
		.move   (y_move),
		.q1     (y1),
		.q2     (y2)
	);

endmodule

// File: test/ps2_mouse_model.sv
`timescale 1ns/1ps

module ps2_mouse_model
	import ps2_mouse_pkg::*;
(
	input  logic sysclk,
	input  logic clk_line,
	input  logic dat_line,
	output logic clk_oe,
	output logic dat_oe
);
	// Every command byte that the host sent with the oldest first
	logic [7:0] host_log[$];
	logic       busy;
	logic       sending;
	logic       bad_id_once;
	logic [9:0] cmd_bits;
	logic [7:0] id_byte;
	int         frame_errors;

	initial begin
		clk_oe       = 1'b0;
		dat_oe       = 1'b0;
		busy         = 1'b0;
		sending      = 1'b0;
		bad_id_once  = 1'b0;
		frame_errors = 0;
	end

	// One device clock pulse is low for 100 cycles with 50 cycles of high time on each side
	task automatic clock_pulse();
		repeat (50) @(posedge sysclk);
		clk_oe <= 1'b1;
		repeat (100) @(posedge sysclk);
		clk_oe <= 1'b0;
		repeat (50) @(posedge sysclk);
	endtask

	// Sends the first nbits bits of a device frame starting with the start bit
	task automatic send_bits(input logic [7:0] b, input int nbits);
		logic [10:0] bits;
		bits    = {1'b1, ~^b, b, 1'b0};
		sending = 1'b1;
		for (int i = 0; i < nbits; i++) begin
			// Data changes while the clock is high
			@(posedge sysclk);
			dat_oe <= ~bits[i];
			clock_pulse();
		end
		@(posedge sysclk);
		dat_oe <= 1'b0;
		repeat (200) @(posedge sysclk);
		sending = 1'b0;
	endtask

	task automatic send_byte(input logic [7:0] b);
		send_bits(b, 11);
	endtask

	// A frame that stops after the start bit and three data bits
	task automatic stall_frame(input logic [7:0] b);
		send_bits(b, 4);
	endtask

	task automatic power_up();
		send_byte(PS2_REP_BAT_OK);
		send_byte(PS2_REP_ID);
	endtask

	task automatic send_packet(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2);
		send_byte(b0);
		send_byte(b1);
		send_byte(b2);
	endtask

	// The next Reset is answered with a wrong device ID
	task automatic set_bad_id();
		bad_id_once = 1'b1;
	endtask

	// A host request to send holds the clock low, then pulls data low and releases the clock
	always begin
		@(posedge sysclk);
		if (!clk_line && !clk_oe && !sending) begin
			while (!clk_line) @(posedge sysclk);
			if (!dat_line) begin
				busy = 1'b1;
				// Data, parity and stop are read while the clock is high
				for (int i = 0; i < 10; i++) begin
					repeat (50) @(posedge sysclk);
					clk_oe <= 1'b1;
					repeat (100) @(posedge sysclk);
					clk_oe <= 1'b0;
					repeat (50) @(posedge sysclk);
					cmd_bits[i] = dat_line;
				end
				// Data and parity together hold an odd number of ones and the stop bit is high
				if ((^cmd_bits[8:0]) !== 1'b1 || cmd_bits[9] !== 1'b1) begin
					frame_errors++;
				end
				// The acknowledge bit holds data low across the last clock
				dat_oe <= 1'b1;
				clock_pulse();
				dat_oe <= 1'b0;
				host_log.push_back(cmd_bits[7:0]);
				repeat (300) @(posedge sysclk);
				send_byte(PS2_REP_ACK);
				if (cmd_bits[7:0] == PS2_CMD_RESET) begin
					id_byte     = bad_id_once ? 8'h03 : PS2_REP_ID;
					bad_id_once = 1'b0;
					send_byte(PS2_REP_BAT_OK);
					send_byte(id_byte);
				end
				busy = 1'b0;
			end
		end
	end

endmodule

// File: test/tb_ps2_mouse.sv
`timescale 1ns/1ps

module tb_ps2_mouse
	import ps2_mouse_pkg::*;
();
	localparam int NUM_PACKETS = 6;
	localparam int NUM_FRAMES  = 80;
	// Every drain wait is at most 258 ticks, and four extra packets carry small moves
	localparam int TOTAL_STEPS = (NUM_PACKETS + 4) * 260;
	localparam longint WATCH_CYCLES =
		longint'(NUM_FRAMES) * 2500 + longint'(TOTAL_STEPS) * 4096 + 200000;

	logic        sysclk;
	logic        reset;
	logic        host_clk_oe;
	logic        host_dat_oe;
	logic        dev_clk_oe;
	logic        dev_dat_oe;
	logic        ps2clk;
	logic        ps2dat;
	logic        x1, x2, y1, y2, button;
	logic [15:0] lfsr;
	int          x_count, y_count;
	logic        x1_prev, y1_prev;
	logic        exp_xdir, exp_ydir;

	// Both open-drain lines float high through the pull-ups unless a side pulls them low
	assign ps2clk = ~(host_clk_oe | dev_clk_oe);
	assign ps2dat = ~(host_dat_oe | dev_dat_oe);

	ps2_mouse u_dut (
		.sysclk    (sysclk),
		.reset     (reset),
		.ps2clk_in (ps2clk),
		.ps2dat_in (ps2dat),
		.ps2clk_oe (host_clk_oe),
		.ps2dat_oe (host_dat_oe),
		.x1        (x1),
		.x2        (x2),
		.y1        (y1),
		.y2        (y2),
		.button    (button)
	);

	ps2_mouse_model u_mouse (
		.sysclk   (sysclk),
		.clk_line (ps2clk),
		.dat_line (ps2dat),
		.clk_oe   (dev_clk_oe),
		.dat_oe   (dev_dat_oe)
	);

	initial sysclk = 1'b0;
	always #10 sysclk = ~sysclk;

	task automatic check(input string name, input int expected, input int actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %0h actual %0h", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// Fibonacci LFSR with taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[6:0], lfsr[0]};
		end
	endtask

	// Bit 9 is the direction with 1 for negative and bits 8:0 are the step count
	// From an empty accumulator the add is never blocked, and every count drains as one step
	function automatic logic [9:0] expected_steps(input logic sign, input logic [7:0] mag);
		int count;
		count = sign ? (256 - int'(mag)) : int'(mag);
		return {sign, 9'(count)};
	endfunction

	// Counts toggles of x1 and y1 and checks the direction line on each one
	always @(posedge sysclk) begin
		if (reset) begin
			x_count <= 0;
			y_count <= 0;
		end else begin
			if (x1 !== x1_prev) begin
				x_count <= x_count + 1;
				check("x2 direction", exp_xdir ? x1 : !x1, x2);
			end
			if (y1 !== y1_prev) begin
				y_count <= y_count + 1;
				check("y2 direction", exp_ydir ? y1 : !y1, y2);
			end
		end
		x1_prev <= x1;
		y1_prev <= y1;
	end

	initial begin
		repeat (WATCH_CYCLES) @(posedge sysclk);
		$display("Timeout: the tests did not finish in the allowed number of cycles");
		$display("SIMULATION FAILED");
		$fatal(1);
	end

	// Waits until the model has logged n host commands and answered the last one
	task automatic wait_commands(input int n);
		while (u_mouse.host_log.size() < n) @(posedge sysclk);
		while (u_mouse.busy) @(posedge sysclk);
		repeat (50) @(posedge sysclk);
		check("host frame errors", 0, u_mouse.frame_errors);
	endtask

	// Sends one packet and checks both axes once they have drained
	task automatic run_packet(input string name, input logic [7:0] b0, input logic [7:0] b1,
			input logic [7:0] b2);
		logic [9:0] ex, ey;
		int         x0, y0, longest;
		ex       = expected_steps(b0[4], b1);
		ey       = expected_steps(b0[5], b2);
		exp_xdir = ex[9];
		exp_ydir = ey[9];
		x0       = x_count;
		y0       = y_count;
		u_mouse.send_packet(b0, b1, b2);
		longest = (ex[8:0] > ey[8:0]) ? int'(ex[8:0]) : int'(ey[8:0]);
		repeat ((longest + 2) * 4096) @(posedge sysclk);
		check({name, " x steps"}, int'(ex[8:0]), x_count - x0);
		check({name, " y steps"}, int'(ey[8:0]), y_count - y0);
	endtask

	initial begin
		logic [7:0] sx, sy, mx, my;
		int         x0;
		int         y0;
		lfsr     = 16'd6503;
		exp_xdir = 1'b0;
		exp_ydir = 1'b0;
		reset    = 1'b1;
		repeat (4) @(posedge sysclk);
		reset <= 1'b0;
		@(posedge sysclk);

		check("reset x1", 0, x1);
		check("reset x2", 0, x2);
		check("reset y1", 0, y1);
		check("reset y2", 0, y2);
		check("reset button", 1, button);
		check("reset clk_oe", 0, host_clk_oe);
		check("reset dat_oe", 0, host_dat_oe);

		// In a normal bring-up the host enables reporting after the ID
		u_mouse.power_up();
		wait_commands(1);
		check("first command", PS2_CMD_ENABLE, u_mouse.host_log[0]);
		run_packet("bring-up packet", 8'h08, 8'h05, 8'h03);

		// A stalled frame forces Reset, then a wrong ID forces a second Reset
		u_mouse.set_bad_id();
		u_mouse.stall_frame(8'h08);
		wait_commands(4);
		check("stall reset", PS2_CMD_RESET, u_mouse.host_log[1]);
		check("bad id reset", PS2_CMD_RESET, u_mouse.host_log[2]);
		check("re-enable", PS2_CMD_ENABLE, u_mouse.host_log[3]);

		for (int i = 0; i < NUM_PACKETS; i++) begin
			rand_bits(1, sx);
			rand_bits(8, mx);
			rand_bits(1, sy);
			rand_bits(8, my);
			run_packet("random packet", {2'b00, sy[0], sx[0], 4'b1000}, mx, my);
		end

		run_packet("button press", 8'h09, 8'h00, 8'h00);
		check("button pressed", 0, button);
		run_packet("button release", 8'h08, 8'h00, 8'h00);
		check("button released", 1, button);

		// Bytes with bit 3 clear are not a packet start, so nothing moves
		// Taking 8'h17 as byte 0 would turn the next two bytes into movement
		x0 = x_count;
		y0 = y_count;
		u_mouse.send_packet(8'h17, 8'h05, 8'h03);
		repeat (2 * 4096) @(posedge sysclk);
		check("misaligned x", x0, x_count);
		check("misaligned y", y0, y_count);
		run_packet("after resync", 8'h38, 8'hF0, 8'hFA);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: all.f
hdl/ps2_mouse_pkg.sv
hdl/ps2_link.sv
hdl/mouse_ctrl.sv
hdl/quad_axis.sv
hdl/ps2_mouse.sv
test/ps2_mouse_model.sv
test/tb_ps2_mouse.sv

// File: Makefile
SRCS := $(shell cat all.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_ps2_mouse: all.f $(SRCS)
	verilator --binary --timing --assert -f all.f --top-module tb_ps2_mouse -Mdir obj_dir

run: obj_dir/Vtb_ps2_mouse
	@out=$$(./obj_dir/Vtb_ps2_mouse); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
